/* run.sh */
#!/bin/sh
# Builds the long_fifo testbench with Verilator and runs it.
# The exit status is zero only when the log holds the pass line.

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
sim_name=sim_long_fifo
log_file=sim.log

verilator --binary --timing --assert \
    --top-module tb_long_fifo \
    -f tb.f \
    -Mdir "$build_dir" -o "$sim_name"
if [ $? -ne 0 ]; then
    echo "Verilator build failed."
    exit 1
fi

"./$build_dir/$sim_name" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status."
    exit 1
fi

if grep -qx "all tests passed" "$log_file"; then
    echo "Result: PASS"
    exit 0
fi
echo "Result: FAIL"
exit 1

/* tb.f */
verilog/long_fifo_pkg.sv
verilog/lane_fifo_if.sv
verilog/gray_ptr_sync.sv
verilog/fifo_write_ctrl.sv
verilog/fifo_read_ctrl.sv
verilog/long_fifo_4bit.sv
verilog/long_fifo.sv
verification/tb_clock_gen.sv
verification/tb_long_fifo.sv

/* verification/tb_clock_gen.sv */
module tb_clock_gen #(
    parameter int HALF_PERIOD = 5                                 // Half of the clock period.
) (
    output logic clk
);

    initial begin
        clk = 1'b0;                                               // First rise after one half period.
        forever #HALF_PERIOD clk = ~clk;                          // Free running square wave.
    end

endmodule

/* verification/tb_long_fifo.sv */
module tb_long_fifo;

    localparam int WR_HALF        = 5;                            // wr_clk period of 10.
    localparam int RD_HALF        = 7;                            // rd_clk period of 14.
    localparam int WAIT_LIMIT     = 50;                           // Cycles one flag wait may take.
    localparam int RANDOM_CYCLES  = 2000;                         // wr_clk cycles of random traffic.
    localparam int FULL_MIN_FILL  = 13;                           // Up to 3 reads still crossing.
    localparam int EMPTY_MAX_FILL = 4;                            // Up to 4 writes still crossing.
    localparam logic [31:0] SEED  = 32'd32112;

    logic                 wr_clk;
    logic                 rd_clk;
    logic                 reset;
    logic                 wr_en;
    logic                 rd_en;
    long_fifo_pkg::data_t din;
    long_fifo_pkg::data_t dout;
    logic                 full;
    logic                 empty;

    long_fifo_pkg::data_t model_q [$];                            // Words the FIFO should hold.
    long_fifo_pkg::data_t expected_dout;                          // Word of the last accepted read.
    logic [31:0]          wr_lfsr;                                // Stream for the write side.
    logic [31:0]          rd_lfsr;                                // Stream for the read side.
    logic [31:0]          draw;
    logic                 writer_done;

    tb_clock_gen #(.HALF_PERIOD(WR_HALF)) u_wr_clock (.clk(wr_clk));
    tb_clock_gen #(.HALF_PERIOD(RD_HALF)) u_rd_clock (.clk(rd_clk));

    long_fifo dut (
        .wr_clk (wr_clk),
        .rd_clk (rd_clk),
        .reset  (reset),
        .wr_en  (wr_en),
        .rd_en  (rd_en),
        .din    (din),
        .dout   (dout),
        .full   (full),
        .empty  (empty)
    );

    // ##################################################
    // Random source and failure reporting
    // ##################################################

    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ 32'hD000_0001) : (state >> 1);  // Galois form.
    endfunction

    task automatic draw_bits(inout logic [31:0] state, input int count, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < count; i++) begin
            state = lfsr_step(state);                             // One step per bit taken.
            bits  = {bits[30:0], state[0]};
        end
    endtask

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("tests failed");
        $fatal(1, "Simulation stopped at the first failure.");
    endtask

    task automatic check_value(input string test, input int expected, input int actual);
        assert (expected == actual)
            else report_failure($sformatf("ERR %s: expected 'h%0h, actual 'h%0h",
                                          test, expected, actual));
    endtask

    // ##################################################
    // Bus steps and waits
    // ##################################################

    task automatic next_wr_slot();
        @(posedge wr_clk);
        #1;                                                       // Outputs of this edge are settled.
    endtask

    task automatic next_rd_slot();
        @(posedge rd_clk);
        #1;
    endtask

    // The pointer synchronizers need up to three destination cycles.
    task automatic cross_domain_settle();
        for (int i = 0; i < 3; i++) next_rd_slot();
        for (int i = 0; i < 3; i++) next_wr_slot();
    endtask

    task automatic write_word(input long_fifo_pkg::data_t word);
        next_wr_slot();
        wr_en = 1'b1;
        din   = word;
        if (!full) model_q.push_back(word);                       // Accepted on the coming edge.
        next_wr_slot();
        wr_en = 1'b0;                                             // Full now shows that edge.
    endtask

    task automatic read_and_check(input string test);
        next_rd_slot();
        rd_en = 1'b1;
        if (!empty) begin
            assert (model_q.size() > 0)
                else report_failure($sformatf("%s: FIFO gave a read with nothing stored.", test));
            expected_dout = model_q.pop_front();
        end
        next_rd_slot();
        rd_en = 1'b0;
        check_value(test, int'(expected_dout), int'(dout));       // Unchanged if nothing was read.
    endtask

    task automatic wait_not_empty(input string test);
        int cycles;
        cycles = 0;
        while (empty) begin
            next_rd_slot();
            cycles++;
            if (cycles > WAIT_LIMIT)
                report_failure($sformatf("%s: timed out waiting for empty to fall.", test));
        end
    endtask

    task automatic wait_full_low(input string test);
        int cycles;
        cycles = 0;
        while (full) begin
            next_wr_slot();
            cycles++;
            if (cycles > WAIT_LIMIT)
                report_failure($sformatf("%s: timed out waiting for full to fall.", test));
        end
    endtask

    task automatic pass_single_word(input long_fifo_pkg::data_t word, input string test);
        write_word(word);
        wait_not_empty(test);
        read_and_check(test);
    endtask

    // ##################################################
    // Random traffic
    // ##################################################

    task automatic random_writer();
        logic [31:0] bits;
        for (int cycle = 0; cycle < RANDOM_CYCLES; cycle++) begin
            next_wr_slot();
            assert (!full || model_q.size() >= FULL_MIN_FILL)
                else report_failure($sformatf("random: full high with %0d words stored.",
                                              model_q.size()));
            draw_bits(wr_lfsr, 2, bits);
            wr_en = (cycle < RANDOM_CYCLES / 2) ? |bits[1:0] : &bits[1:0];  // Fill, then drain.
            draw_bits(wr_lfsr, long_fifo_pkg::DATA_WIDTH, bits);
            din = bits[long_fifo_pkg::DATA_WIDTH-1:0];
            if (wr_en && !full) model_q.push_back(din);
        end
        next_wr_slot();
        wr_en       = 1'b0;
        writer_done = 1'b1;
    endtask

    task automatic random_reader();
        logic [31:0] bits;
        int          cycles;
        cycles = 0;
        next_rd_slot();
        while (!(writer_done && model_q.size() == 0)) begin
            check_value("random", int'(expected_dout), int'(dout));
            assert (!empty || model_q.size() <= EMPTY_MAX_FILL)
                else report_failure($sformatf("random: empty high with %0d words stored.",
                                              model_q.size()));
            draw_bits(rd_lfsr, 1, bits);
            rd_en = bits[0];
            if (rd_en && !empty) begin
                assert (model_q.size() > 0)
                    else report_failure("random: FIFO gave a read with nothing stored.");
                expected_dout = model_q.pop_front();
            end
            next_rd_slot();
            cycles++;
            if (cycles > RANDOM_CYCLES + WAIT_LIMIT)
                report_failure("random: timed out waiting for the FIFO to drain.");
        end
        rd_en = 1'b0;
        check_value("random", int'(expected_dout), int'(dout));  // The last word read.
    endtask

    // ##################################################
    // Test sequence
    // ##################################################

    initial begin
        reset         = 1'b1;
        wr_en         = 1'b0;
        rd_en         = 1'b0;
        din           = '0;
        wr_lfsr       = SEED;
        rd_lfsr       = SEED;
        writer_done   = 1'b0;
        expected_dout = '0;                                       // dout clears on reset.
        for (int i = 0; i < 10; i++) next_wr_slot();
        reset = 1'b0;
        cross_domain_settle();

        check_value("reset_empty", 1, int'(empty));
        check_value("reset_full", 0, int'(full));
        check_value("reset_dout", 0, int'(dout));

        pass_single_word('1, "all_ones");                         // Includes the partial lane.
        for (int i = 0; i < long_fifo_pkg::DATA_WIDTH; i++)
            pass_single_word(long_fifo_pkg::data_t'(1) << i, "walking_one");
        write_word(10'h3FF);                                      // Short burst keeps its order.
        write_word(10'h001);
        write_word(10'h2AA);
        for (int i = 0; i < 3; i++) begin
            wait_not_empty("order");
            read_and_check("order");
        end

        for (int i = 0; i <= long_fifo_pkg::DEPTH; i++) begin
            draw_bits(wr_lfsr, long_fifo_pkg::DATA_WIDTH, draw);
            write_word(draw[long_fifo_pkg::DATA_WIDTH-1:0]);      // The 17th word is dropped.
            check_value("fill_full", int'(i >= long_fifo_pkg::DEPTH - 1), int'(full));
        end
        cross_domain_settle();
        for (int i = 0; i < long_fifo_pkg::DEPTH; i++) begin
            read_and_check("fill_drain");
            check_value("fill_empty", int'(i == long_fifo_pkg::DEPTH - 1), int'(empty));
        end
        check_value("fill_model", 0, model_q.size());
        wait_full_low("fill");

        for (int i = 0; i < 4; i++) begin
            read_and_check("empty_read");                         // dout must hold its word.
            check_value("empty_flag", 1, int'(empty));
        end
        pass_single_word(10'h2C5, "empty_read");
        check_value("empty_after", 1, int'(empty));

        fork
            random_writer();
            random_reader();
        join
        check_value("random_empty", 1, int'(empty));

        $display("all tests passed");
        $finish;
    end

endmodule

/* verilog/fifo_read_ctrl.sv */
module fifo_read_ctrl (
    input  logic                 rd_clk,
    input  logic                 reset,                           // Raw reset, synchronized below.
    input  logic                 rd_en,
    input  long_fifo_pkg::ptr_t  wr_ptr_gray_sync,                // Write pointer in rd_clk domain.
    output long_fifo_pkg::ptr_t  rd_ptr_gray,                     // Registered Gray read pointer.
    output long_fifo_pkg::addr_t rd_addr,                         // Memory address for this read.
    output logic                 rd_accept,                       // Read takes effect this edge.
    output logic                 empty
);

    logic                reset_meta;                              // First reset synchronizer stage.
    logic                reset_sync;                              // Reset as seen by rd_clk logic.
    long_fifo_pkg::ptr_t rd_bin;                                  // Binary read pointer.
    long_fifo_pkg::ptr_t rd_bin_next;
    long_fifo_pkg::ptr_t rd_gray_next;
    logic                empty_next;

    // ##################################################
    // Reset synchronizer
    // ##################################################

    always_ff @(posedge rd_clk) begin
        reset_meta <= reset;                                      // Bring reset into rd_clk.
        reset_sync <= reset_meta;                                 // Second stage, safe to fan out.
    end

    // ##################################################
    // Pointer and flag logic
    // ##################################################

    assign rd_accept    = rd_en && !empty;                        // Reads while empty do nothing.
    assign rd_bin_next  = rd_bin + long_fifo_pkg::ptr_t'(rd_accept);
    assign rd_gray_next = (rd_bin_next >> 1) ^ rd_bin_next;       // Binary to Gray conversion.
    assign rd_addr      = rd_bin[long_fifo_pkg::DEPTH_LOG2-1:0];  // Drop the wrap bit.

    // Equal pointers, wrap bit included, mean nothing is left to read.
    // The write pointer lags by the synchronizer, so empty may linger a few cycles.
    assign empty_next = (rd_gray_next == wr_ptr_gray_sync);

    always_ff @(posedge rd_clk) begin
        if (reset_sync) begin
            rd_bin      <= '0;                                    // Start at entry zero.
            rd_ptr_gray <= '0;
            empty       <= 1'b1;                                  // Nothing stored after reset.
        end else begin
            rd_bin      <= rd_bin_next;                           // Advance on an accepted read.
            rd_ptr_gray <= rd_gray_next;                          // Registered for the synchronizer.
            empty       <= empty_next;                            // Set by the last accepted read.
        end
    end

    // An empty FIFO holds its read pointer, so the reader never passes the writer.
    assert property (@(posedge rd_clk) disable iff (reset_sync)
        empty |=> $stable(rd_ptr_gray))
        else $error("Read pointer advanced while the FIFO was empty.");

endmodule

/* verilog/fifo_write_ctrl.sv */
module fifo_write_ctrl (
    input  logic                 wr_clk,
    input  logic                 reset,                           // Raw reset, synchronized below.
    input  logic                 wr_en,
    input  long_fifo_pkg::ptr_t  rd_ptr_gray_sync,                // Read pointer in wr_clk domain.
    output long_fifo_pkg::ptr_t  wr_ptr_gray,                     // Registered Gray write pointer.
    output long_fifo_pkg::addr_t wr_addr,                         // Memory address for this write.
    output logic                 wr_accept,                       // Write takes effect this edge.
    output logic                 full
);

    logic                reset_meta;                              // First reset synchronizer stage.
    logic                reset_sync;                              // Reset as seen by wr_clk logic.
    long_fifo_pkg::ptr_t wr_bin;                                  // Binary write pointer.
    long_fifo_pkg::ptr_t wr_bin_next;
    long_fifo_pkg::ptr_t wr_gray_next;
    long_fifo_pkg::ptr_t rd_ptr_wrapped;                          // Read pointer one lap ahead.
    logic                full_next;

    // ##################################################
    // Reset synchronizer
    // ##################################################

    always_ff @(posedge wr_clk) begin
        reset_meta <= reset;                                      // Bring reset into wr_clk.
        reset_sync <= reset_meta;                                 // Second stage, safe to fan out.
    end

    // ##################################################
    // Pointer and flag logic
    // ##################################################

    assign wr_accept    = wr_en && !full;                         // Writes while full are dropped.
    assign wr_bin_next  = wr_bin + long_fifo_pkg::ptr_t'(wr_accept);
    assign wr_gray_next = (wr_bin_next >> 1) ^ wr_bin_next;       // Binary to Gray conversion.
    assign wr_addr      = wr_bin[long_fifo_pkg::DEPTH_LOG2-1:0];  // Drop the wrap bit.

    // In Gray code a pointer exactly one lap ahead differs in its two top bits only.
    assign rd_ptr_wrapped = {~rd_ptr_gray_sync[long_fifo_pkg::DEPTH_LOG2 -: 2],
                             rd_ptr_gray_sync[long_fifo_pkg::DEPTH_LOG2-2:0]};

    assign full_next = (wr_gray_next == rd_ptr_wrapped);          // The next write fills the FIFO.

    always_ff @(posedge wr_clk) begin
        if (reset_sync) begin
            wr_bin      <= '0;                                    // Start at entry zero.
            wr_ptr_gray <= '0;
            full        <= 1'b0;                                  // An empty FIFO is never full.
        end else begin
            wr_bin      <= wr_bin_next;                           // Advance on an accepted write.
            wr_ptr_gray <= wr_gray_next;                          // Registered for the synchronizer.
            full        <= full_next;                             // Set by the 16th unread write.
        end
    end

    // A full FIFO holds its write pointer, so no entry is overwritten before it is read.
    assert property (@(posedge wr_clk) disable iff (reset_sync)
        full |=> $stable(wr_ptr_gray))
        else $error("Write pointer advanced while the FIFO was full.");

endmodule

/* verilog/gray_ptr_sync.sv */
module gray_ptr_sync (
    input  logic                clk,                              // Destination domain clock.
    input  logic                reset,
    input  long_fifo_pkg::ptr_t ptr_gray,                         // Gray pointer from the source side.
    output long_fifo_pkg::ptr_t ptr_gray_sync                     // Same pointer, two cycles later.
);

    // ##################################################
    // Two stage pointer synchronizer
    // ##################################################

    // First stage may go metastable.
    // The Gray code keeps a late bit from tearing the value apart,
    // since only one bit moves per source increment.
    long_fifo_pkg::ptr_t ptr_meta;

    always_ff @(posedge clk) begin
        if (reset) begin
            ptr_meta      <= '0;                                  // Both pointers start at zero.
            ptr_gray_sync <= '0;                                  // Matches the reset source pointer.
        end else begin
            ptr_meta      <= ptr_gray;                            // Capture the foreign pointer.
            ptr_gray_sync <= ptr_meta;                            // Second stage settles the value.
        end
    end

endmodule

/* verilog/lane_fifo_if.sv */
interface lane_fifo_if;

    // Write side, sourced by the word splitter.
    long_fifo_pkg::lane_data_t wr_data;                           // Lane slice of the word to store.
    logic                      wr_en;                             // Write strobe, shared by all lanes.

    // Read side strobe, also from the splitter.
    logic                      rd_en;                             // Read strobe, shared by all lanes.

    // Returned by the lane FIFO.
    long_fifo_pkg::lane_data_t rd_data;                           // Registered read word of this lane.
    logic                      full;                              // Lane full flag in wr_clk domain.
    logic                      empty;                             // Lane empty flag in rd_clk domain.

    modport splitter (
        output wr_data,
        output wr_en,
        output rd_en,
        input  rd_data,
        input  full,
        input  empty
    );

    modport lane (
        input  wr_data,
        input  wr_en,
        input  rd_en,
        output rd_data,
        output full,
        output empty
    );

endinterface

/* verilog/long_fifo.sv */
module long_fifo (
    input  logic                 wr_clk,
    input  logic                 rd_clk,
    input  logic                 reset,
    input  logic                 wr_en,
    input  logic                 rd_en,
    input  long_fifo_pkg::data_t din,                             // Word to store.
    output long_fifo_pkg::data_t dout,                            // Word from the last accepted read.
    output logic                 full,
    output logic                 empty
);

    // Padded word, a whole number of lanes wide.
    logic [long_fifo_pkg::LANE_COUNT*long_fifo_pkg::LANE_WIDTH-1:0] din_padded;
    logic [long_fifo_pkg::LANE_COUNT*long_fifo_pkg::LANE_WIDTH-1:0] dout_padded;

    logic [long_fifo_pkg::LANE_COUNT-1:0] lane_full;              // One full flag per lane.
    logic [long_fifo_pkg::LANE_COUNT-1:0] lane_empty;             // One empty flag per lane.

    // Unused upper bits of the last lane are stored as zero.
    assign din_padded = (long_fifo_pkg::LANE_COUNT * long_fifo_pkg::LANE_WIDTH)'(din);

    // ##################################################
    // Lane array
    // ##################################################

    for (genvar i = 0; i < long_fifo_pkg::LANE_COUNT; i++) begin : g_lane
        lane_fifo_if lane_bus ();                                 // Signals of lane i.

        assign lane_bus.wr_data = din_padded[i*long_fifo_pkg::LANE_WIDTH +: long_fifo_pkg::LANE_WIDTH];
        assign lane_bus.wr_en   = wr_en;                          // Every lane writes together.
        assign lane_bus.rd_en   = rd_en;                          // Every lane reads together.

        assign dout_padded[i*long_fifo_pkg::LANE_WIDTH +: long_fifo_pkg::LANE_WIDTH] =
            lane_bus.rd_data;
        assign lane_full[i]  = lane_bus.full;
        assign lane_empty[i] = lane_bus.empty;

        long_fifo_4bit u_lane (
            .wr_clk (wr_clk),
            .rd_clk (rd_clk),
            .reset  (reset),
            .port   (lane_bus.lane)
        );
    end

    // Lanes run in lockstep, so lane 0 speaks for all of them.
    assign full  = lane_full[0];
    assign empty = lane_empty[0];
    assign dout  = dout_padded[long_fifo_pkg::DATA_WIDTH-1:0];    // Padding bits are dropped.

    // A lane out of step would split a word across two entries.
    assert property (@(posedge wr_clk) disable iff (reset)
        lane_full == {long_fifo_pkg::LANE_COUNT{lane_full[0]}})
        else $error("Lane full flags disagree.");

    assert property (@(posedge rd_clk) disable iff (reset)
        lane_empty == {long_fifo_pkg::LANE_COUNT{lane_empty[0]}})
        else $error("Lane empty flags disagree.");

endmodule

/* verilog/long_fifo_4bit.sv */
module long_fifo_4bit (
    input logic       wr_clk,
    input logic       rd_clk,
    input logic       reset,                                      // Synchronized in each domain.
    lane_fifo_if.lane port                                        // Lane data, strobes and flags.
);

    long_fifo_pkg::lane_data_t mem [long_fifo_pkg::DEPTH];        // Dual clock storage array.

    long_fifo_pkg::addr_t wr_addr;
    long_fifo_pkg::addr_t rd_addr;
    logic                 wr_accept;
    logic                 rd_accept;
    long_fifo_pkg::ptr_t  wr_ptr_gray;                            // Write pointer, wr_clk domain.
    long_fifo_pkg::ptr_t  rd_ptr_gray;                            // Read pointer, rd_clk domain.
    long_fifo_pkg::ptr_t  wr_ptr_gray_sync;                       // Write pointer moved to rd_clk.
    long_fifo_pkg::ptr_t  rd_ptr_gray_sync;                       // Read pointer moved to wr_clk.

    // ##################################################
    // Controllers and pointer crossings
    // ##################################################

    fifo_write_ctrl u_write_ctrl (
        .wr_clk           (wr_clk),
        .reset            (reset),
        .wr_en            (port.wr_en),
        .rd_ptr_gray_sync (rd_ptr_gray_sync),
        .wr_ptr_gray      (wr_ptr_gray),
        .wr_addr          (wr_addr),
        .wr_accept        (wr_accept),
        .full             (port.full)
    );

    fifo_read_ctrl u_read_ctrl (
        .rd_clk           (rd_clk),
        .reset            (reset),
        .rd_en            (port.rd_en),
        .wr_ptr_gray_sync (wr_ptr_gray_sync),
        .rd_ptr_gray      (rd_ptr_gray),
        .rd_addr          (rd_addr),
        .rd_accept        (rd_accept),
        .empty            (port.empty)
    );

    // Write pointer crosses into the read domain.
    gray_ptr_sync u_wr_ptr_sync (
        .clk           (rd_clk),
        .reset         (reset),
        .ptr_gray      (wr_ptr_gray),
        .ptr_gray_sync (wr_ptr_gray_sync)
    );

    gray_ptr_sync u_rd_ptr_sync (                                 // Read pointer into write domain.
        .clk           (wr_clk),
        .reset         (reset),
        .ptr_gray      (rd_ptr_gray),
        .ptr_gray_sync (rd_ptr_gray_sync)
    );

    // ##################################################
    // Storage and registered read port
    // ##################################################

    always_ff @(posedge wr_clk) begin
        if (wr_accept) mem[wr_addr] <= port.wr_data;              // Store only accepted writes.
    end

    always_ff @(posedge rd_clk) begin
        if (reset) port.rd_data <= '0;                            // Output word clears on reset.
        else if (rd_accept) port.rd_data <= mem[rd_addr];         // Holds until the next read.
    end

    // An unknown data bit written now would surface on dout one FIFO trip later.
    assert property (@(posedge wr_clk) wr_accept |-> !$isunknown(port.wr_data))
        else $error("Unknown write data accepted into a lane FIFO.");

endmodule

/* verilog/long_fifo_pkg.sv */
package long_fifo_pkg;

    // ##################################################
    // Word and lane geometry
    // ##################################################

    localparam int DATA_WIDTH = 10;                               // Width of one user word.
    localparam int LANE_WIDTH = 4;                                // Bits carried by each lane FIFO.
    localparam int LANE_COUNT = (DATA_WIDTH + LANE_WIDTH - 1) / LANE_WIDTH;  // Rounded up, so 3.

    // ##################################################
    // Storage geometry
    // ##################################################

    localparam int DEPTH_LOG2 = 4;                                // Address bits of a lane memory.
    localparam int DEPTH      = 1 << DEPTH_LOG2;                  // Entries per lane, 16.

    // ##################################################
    // Vector types
    // ##################################################

    // A full user word at the top-level ports.
    typedef logic [DATA_WIDTH-1:0] data_t;

    typedef logic [LANE_WIDTH-1:0] lane_data_t;                   // One lane's slice of a word.

    typedef logic [DEPTH_LOG2-1:0] addr_t;                        // Index into a lane memory.

    // The extra top bit is the wrap bit.
    // It tells a full FIFO apart from an empty one.
    typedef logic [DEPTH_LOG2:0] ptr_t;

endpackage
